/* sources.f */
+incdir+sim
common/pwr_rail_pkg.sv
common/pwr_regs_pkg.sv
sequencer/rail_io_map.sv
sequencer/rail_sequencer.sv
regs/axil_reg_slave.sv
src/power_controller_top.sv
sim/power_controller_tb.sv

/* sim/tb_axil_tasks.svh */
// AXI4-Lite host tasks
// Single write and read transfers with each response held back for a random number of cycles

task automatic axil_write(input reg_addr_t num, input logic [31:0] data);
	int cycles;
	int hold;
	cycles = 0;
	hold = $urandom_range(3, 0);
	axil_req.awvalid <= 1'b1;
	axil_req.awaddr <= {num, 2'b00};
	axil_req.wvalid <= 1'b1;
	axil_req.wdata <= data;
	axil_req.wstrb <= 4'hf;
	@(posedge clk_in);
	while (!(axil_rsp.awready && axil_rsp.wready) && cycles < 16) begin
		@(posedge clk_in);
		cycles++;
	end
	axil_req.awvalid <= 1'b0;
	axil_req.wvalid <= 1'b0;
	if (!(axil_rsp.awready && axil_rsp.wready)) begin
		$display("write to register %h was not accepted within 16 cycles", num);
		error_count++;
	end else begin
		// Response must stay up while bready is held back
		repeat (hold) begin
			@(posedge clk_in);
			assert (axil_rsp.bvalid) else begin
				$display("write response for register %h dropped before bready", num);
				error_count++;
			end
		end
		axil_req.bready <= 1'b1;
		@(posedge clk_in);
		assert (axil_rsp.bvalid && axil_rsp.bresp == 2'b00) else begin
			$display("write to register %h ended without an OKAY response", num);
			error_count++;
		end
		axil_req.bready <= 1'b0;
	end
endtask

task automatic axil_read(input reg_addr_t num, output logic [7:0] data);
	int cycles;
	int hold;
	cycles = 0;
	hold = $urandom_range(3, 0);
	data = 8'h00;
	axil_req.arvalid <= 1'b1;
	axil_req.araddr <= {num, 2'b00};
	@(posedge clk_in);
	while (!axil_rsp.arready && cycles < 16) begin
		@(posedge clk_in);
		cycles++;
	end
	axil_req.arvalid <= 1'b0;
	if (!axil_rsp.arready) begin
		$display("read of register %h was not accepted within 16 cycles", num);
		error_count++;
	end else begin
		repeat (hold) begin
			@(posedge clk_in);
			assert (axil_rsp.rvalid) else begin
				$display("read response for register %h dropped before rready", num);
				error_count++;
			end
		end
		axil_req.rready <= 1'b1;
		@(posedge clk_in);
		assert (axil_rsp.rvalid && axil_rsp.rresp == 2'b00) else begin
			$display("read of register %h ended without an OKAY response", num);
			error_count++;
		end
		assert (axil_rsp.rdata[31:8] == 24'h000000) else begin
			$display("MISMATCH at %0t: rdata[31:8] expected 000000, seen %h", $time,
				axil_rsp.rdata[31:8]);
			error_count++;
		end
		data = axil_rsp.rdata[7:0];
		axil_req.rready <= 1'b0;
	end
endtask

task automatic read_check(input reg_addr_t num, input logic [7:0] expected, input string name);
	logic [7:0] seen;
	axil_read(num, seen);
	assert (seen === expected) else begin
		$display("MISMATCH at %0t: %s expected %h, seen %h", $time, name, expected, seen);
		error_count++;
	end
endtask

/* sim/power_controller_tb.sv */
// Power controller testbench
// Board supply model with fault injection, rail order checks and register tests
`timescale 1ns/1ps

module power_controller_tb;
	import pwr_rail_pkg::*;
	import pwr_regs_pkg::*;

	localparam int delay_cycles = 16;
	localparam int timeout_cycles = 64;
	localparam int atx_timeout_cycles = 256;
	localparam int seq_bound = rail_count * (delay_cycles + 12);
	// Six tests with none longer than a few full sequences
	localparam int watchdog_cycles = 8 * (4 * seq_bound + 800);

	logic clk_in;
	logic reset;
	logic sysen;
	logic bmc_boot_complete_n;
	logic cpub_present_n;
	rail_pg_pins_t pg_pins = '0;
	axil_req_t axil_req;
	rail_en_pins_t en_pins;
	logic sysgood;
	logic cpub_clk_oe;
	axil_rsp_t axil_rsp;

	rail_vec_t en_rails;
	rail_vec_t pg_rails;
	rail_vec_t en_prev = '0;
	rail_vec_t fault_mask;
	logic [3:0][rail_count-1:0] en_hist = '0;
	int pg_age [rail_count];
	int cycle_count = 0;
	int error_count = 0;
	int test_count = 0;
	int test_errors = 0;
	int start_cycle;
	logic bmc_seen = 1'b1;
	logic order_check;
	logic cpub_check;
	logic [7:0] rd_value;
	logic [31:0] rand_data;

	// The pin structs list ATX first, so rail 0 sits in the top bit
	function automatic rail_vec_t reverse_rails(input rail_vec_t v);
		rail_vec_t r;
		for (int i = 0; i < rail_count; i++) begin
			r[i] = v[rail_count - 1 - i];
		end
		return r;
	endfunction

	function automatic rail_vec_t en_pins_to_rails(input rail_en_pins_t p);
		rail_vec_t r;
		logic [16:0] b;
		b = p;
		for (int i = 0; i < 13; i++) begin
			r[i] = b[16 - i];
		end
		r[13] = p.vddrab_en;
		r[14] = p.vddrcd_en;
		return r;
	endfunction

	// Nearest rail below or above that is really switched
	function automatic int prev_active(input int idx);
		int k;
		k = idx - 1;
		while (k >= 0 && cpub_present_n && cpub_rail_mask[k]) begin
			k--;
		end
		return k;
	endfunction

	function automatic int next_active(input int idx);
		int k;
		k = idx + 1;
		while (k < rail_count && cpub_present_n && cpub_rail_mask[k]) begin
			k++;
		end
		return (k < rail_count) ? k : -1;
	endfunction

	assign en_rails = en_pins_to_rails(en_pins);
	assign pg_rails = reverse_rails(rail_vec_t'(pg_pins));

	power_controller_top #(
		.DELAY_CYCLES(delay_cycles),
		.TIMEOUT_CYCLES(timeout_cycles),
		.ATX_TIMEOUT_CYCLES(atx_timeout_cycles)
	) power_controller_top_inst (
		.clk_in(clk_in),
		.reset(reset),
		.sysen(sysen),
		.bmc_boot_complete_n(bmc_boot_complete_n),
		.cpub_present_n(cpub_present_n),
		.pg_pins(pg_pins),
		.axil_req(axil_req),
		.en_pins(en_pins),
		.sysgood(sysgood),
		.cpub_clk_oe(cpub_clk_oe),
		.axil_rsp(axil_rsp)
	);

	always #50 clk_in = ~clk_in;

	always @(posedge clk_in) begin
		cycle_count <= cycle_count + 1;
	end

	// Supply model where power-good follows its enable 5 cycles later
	always @(posedge clk_in) begin
		en_hist <= {en_hist[2:0], en_rails};
		pg_pins <= rail_pg_pins_t'(reverse_rails(en_hist[3] & ~fault_mask));
	end

	always @(posedge clk_in) begin : rail_checks
		int lower;
		int upper;
		en_prev <= en_rails;
		bmc_seen <= bmc_boot_complete_n;
		for (int i = 0; i < rail_count; i++) begin
			pg_age[i] <= (pg_rails[i] && !reset) ? pg_age[i] + 1 : 0;
		end
		if (!reset) begin
			for (int i = 0; i < rail_count; i++) begin
				lower = prev_active(i);
				upper = next_active(i);
				if (en_rails[i] && !en_prev[i]) begin
					assert ((en_rails >> (i + 1)) == '0) else begin
						$display("rail %0d enabled at %0t above a rail already on", i, $time);
						error_count++;
					end
					if (lower >= 0) begin
						assert (pg_age[lower] >= delay_cycles) else begin
							$display("rail %0d enabled at %0t after rail %0d was good %0d cycles",
								i, $time, lower, pg_age[lower]);
							error_count++;
						end
					end
				end
				if (!en_rails[i] && en_prev[i] && order_check && upper >= 0) begin
					assert (!pg_rails[upper]) else begin
						$display("rail %0d disabled at %0t while rail %0d was still good",
							i, $time, upper);
						error_count++;
					end
				end
			end
			assert (!(sysgood && bmc_seen)) else begin
				$display("sysgood high at %0t while bmc_boot_complete_n was high", $time);
				error_count++;
			end
			// Each termination enable follows its memory supply enable
			assert (en_pins.vttab_en === en_pins.vddrab_en) else begin
				$display("MISMATCH at %0t: vttab_en expected %b, seen %b", $time,
					en_pins.vddrab_en, en_pins.vttab_en);
				error_count++;
			end
			assert (en_pins.vttcd_en === en_pins.vddrcd_en) else begin
				$display("MISMATCH at %0t: vttcd_en expected %b, seen %b", $time,
					en_pins.vddrcd_en, en_pins.vttcd_en);
				error_count++;
			end
			if (cpub_check) begin
				assert ((en_rails & cpub_rail_mask) == '0 && !cpub_clk_oe) else begin
					$display("second-CPU enable or clock output active at %0t", $time);
					error_count++;
				end
			end
		end
	end

	`include "tb_axil_tasks.svh"

	task automatic wait_until_sysgood(input int bound);
		int start;
		start = cycle_count;
		while (!sysgood && cycle_count - start < bound) begin
			@(posedge clk_in);
		end
		if (!sysgood) begin
			$display("sysgood did not rise within %0d cycles at %0t", bound, $time);
			error_count++;
		end
	endtask

	task automatic wait_until_rail_up(input int idx, input int bound);
		int start;
		start = cycle_count;
		while (!en_rails[idx] && cycle_count - start < bound) begin
			@(posedge clk_in);
		end
		if (!en_rails[idx]) begin
			$display("rail %0d was not enabled within %0d cycles", idx, bound);
			error_count++;
		end
	endtask

	// Enables must clear within the bound and power-good follows shortly after
	task automatic wait_until_off(input int bound);
		int start;
		start = cycle_count;
		while (en_rails != '0 && cycle_count - start < bound) begin
			@(posedge clk_in);
		end
		if (en_rails != '0) begin
			$display("enables still on %0d cycles later at %0t", bound, $time);
			error_count++;
		end
		repeat (10) @(posedge clk_in);
		assert (pg_rails == '0) else begin
			$display("power-good still present after shutdown at %0t", $time);
			error_count++;
		end
		repeat (4) @(posedge clk_in);
	endtask

	task automatic finish_test(input string name);
		test_count++;
		$display("test %0d %s: %s, %0d failed checks", test_count, name,
			(error_count == test_errors) ? "pass" : "fail", error_count - test_errors);
		test_errors = error_count;
	endtask

	initial begin
		rand_data = $urandom(32'h14c2);
		clk_in = 1'b0;
		reset = 1'b1;
		sysen = 1'b0;
		bmc_boot_complete_n = 1'b1;
		cpub_present_n = 1'b0;
		axil_req = '0;
		fault_mask = '0;
		order_check = 1'b1;
		cpub_check = 1'b0;
		repeat (4) @(posedge clk_in);
		reset <= 1'b0;
		repeat (2) @(posedge clk_in);

		// Identification, status and an unmapped register
		read_check(reg_version, 8'h09, "version");
		read_check(reg_vendor_0, 8'h52, "vendor_0");
		read_check(reg_vendor_1, 8'h43, "vendor_1");
		read_check(reg_vendor_2, 8'h53, "vendor_2");
		read_check(reg_vendor_3, 8'h20, "vendor_3");
		read_check(reg_status, 8'h20, "status");
		rand_data = $urandom;
		axil_write(8'h20, rand_data);
		read_check(8'h20, 8'h00, "unmapped register");
		read_check(reg_sys_override, 8'h00, "sys_override");
		assert (cpub_clk_oe) else begin
			$display("MISMATCH at %0t: cpub_clk_oe expected 1, seen %b", $time, cpub_clk_oe);
			error_count++;
		end
		finish_test("identification");

		// Power-up with the BMC gate held until the chain is done
		sysen <= 1'b1;
		start_cycle = cycle_count;
		rd_value = 8'h00;
		while (!rd_value[0] && cycle_count - start_cycle < seq_bound) begin
			axil_read(reg_status, rd_value);
		end
		if (!rd_value[0]) begin
			$display("sequence did not complete within %0d cycles", seq_bound);
			error_count++;
		end
		bmc_boot_complete_n <= 1'b0;
		wait_until_sysgood(10);
		read_check(reg_en_lo, 8'hff, "en_lo");
		read_check(reg_en_hi, 8'h7f, "en_hi");
		read_check(reg_pg_lo, 8'hff, "pg_lo");
		read_check(reg_pg_hi, 8'h7f, "pg_hi");
		sysen <= 1'b0;
		wait_until_off(seq_bound);
		finish_test("power-up order");

		cpub_present_n <= 1'b1;
		repeat (4) @(posedge clk_in);
		cpub_check <= 1'b1;
		read_check(reg_status, 8'h00, "status without second CPU");
		sysen <= 1'b1;
		wait_until_sysgood(seq_bound);
		sysen <= 1'b0;
		wait_until_off(seq_bound);
		cpub_check <= 1'b0;
		cpub_present_n <= 1'b0;
		repeat (4) @(posedge clk_in);
		finish_test("second CPU absent");

		// Rail 5 never reports good
		fault_mask <= 15'h0020;
		order_check <= 1'b0;
		sysen <= 1'b1;
		wait_until_rail_up(5, seq_bound);
		wait_until_off(timeout_cycles + 10);
		read_check(reg_status, 8'h36, "status after wait timeout");
		read_check(reg_fail_lo, 8'h20, "fail_lo");
		read_check(reg_fail_hi, 8'h00, "fail_hi");
		fault_mask <= '0;
		order_check <= 1'b1;
		rand_data = $urandom;
		axil_write(reg_clear_err, rand_data);
		read_check(reg_status, 8'h22, "status after error clear");
		wait_until_sysgood(seq_bound);
		sysen <= 1'b0;
		wait_until_off(seq_bound);
		finish_test("wait timeout");

		sysen <= 1'b1;
		wait_until_sysgood(seq_bound);
		fault_mask <= 15'h0004;
		order_check <= 1'b0;
		wait_until_off(20);
		read_check(reg_status, 8'h2e, "status after lost power-good");
		fault_mask <= '0;
		sysen <= 1'b0;
		repeat (4) @(posedge clk_in);
		sysen <= 1'b1;
		order_check <= 1'b1;
		wait_until_sysgood(seq_bound);
		read_check(reg_status, 8'h23, "status after sysen restart");
		sysen <= 1'b0;
		wait_until_off(seq_bound);
		finish_test("lost power-good");

		axil_write(reg_sys_override, 32'h00000001);
		read_check(reg_sys_override, 8'h01, "sys_override set");
		wait_until_sysgood(seq_bound);
		axil_write(reg_sys_override, 32'h00000000);
		wait_until_off(seq_bound);
		read_check(reg_sys_override, 8'h00, "sys_override cleared");
		finish_test("force enable");

		$display("tests run: %0d, failed checks: %0d", test_count, error_count);
		if (error_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk_in);
		$display("watchdog expired after %0d cycles, run did not complete", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* src/power_controller_top.sv */
// Power controller top level
// Joins the board pin mapper, the rail sequencer and the host register slave
`timescale 1ns/1ps

module power_controller_top #(
	parameter int unsigned DELAY_CYCLES = 65536,
	parameter int unsigned TIMEOUT_CYCLES = 8388608,
	parameter int unsigned ATX_TIMEOUT_CYCLES = 67108864
) (
	input logic clk_in,
	input logic reset,
	input logic sysen,
	input logic bmc_boot_complete_n,
	input logic cpub_present_n,
	input pwr_rail_pkg::rail_pg_pins_t pg_pins,
	input pwr_regs_pkg::axil_req_t axil_req,
	output pwr_rail_pkg::rail_en_pins_t en_pins,
	output logic sysgood,
	output logic cpub_clk_oe,
	output pwr_regs_pkg::axil_rsp_t axil_rsp
);
	import pwr_rail_pkg::*;
	import pwr_regs_pkg::*;

	rail_vec_t rail_en;
	rail_vec_t rail_pg;
	seq_status_t seq_status;
	logic force_enable;
	logic clear_err;

	rail_io_map rail_io_map_inst (
		.clk_in(clk_in),
		.reset(reset),
		.cpub_present_n(cpub_present_n),
		.pg_pins(pg_pins),
		.en(rail_en),
		.en_pins(en_pins),
		.pg_sync(rail_pg),
		.cpub_clk_oe(cpub_clk_oe)
	);

	rail_sequencer #(
		.DELAY_CYCLES(DELAY_CYCLES),
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES),
		.ATX_TIMEOUT_CYCLES(ATX_TIMEOUT_CYCLES)
	) rail_sequencer_inst (
		.clk_in(clk_in),
		.reset(reset),
		.sysen(sysen),
		.force_enable(force_enable),
		.bmc_boot_complete_n(bmc_boot_complete_n),
		.pg_sync(rail_pg),
		.clear_err(clear_err),
		.en(rail_en),
		.status(seq_status),
		.sysgood(sysgood)
	);

	axil_reg_slave axil_reg_slave_inst (
		.clk_in(clk_in),
		.reset(reset),
		.axil_req(axil_req),
		.status(seq_status),
		.cpub_present_n(cpub_present_n),
		.axil_rsp(axil_rsp),
		.force_enable(force_enable),
		.clear_err(clear_err)
	);

endmodule

/* regs/axil_reg_slave.sv */
// Host register slave
// AXI4-Lite access to identification, status, enable, power-good and failure
// registers, plus the system enable override and the error clear strobe
`timescale 1ns/1ps

module axil_reg_slave (
	input logic clk_in,
	input logic reset,
	input pwr_regs_pkg::axil_req_t axil_req,
	input pwr_regs_pkg::seq_status_t status,
	input logic cpub_present_n,
	output pwr_regs_pkg::axil_rsp_t axil_rsp,
	output logic force_enable,
	output logic clear_err
);
	import pwr_rail_pkg::*;
	import pwr_regs_pkg::*;

	localparam int hi_bits = rail_count - 8;

	logic aw_ready;
	logic b_valid;
	logic ar_ready;
	logic r_valid;
	logic [7:0] r_data;
	logic wr_fire;
	logic rd_fire;
	reg_addr_t wr_reg;
	reg_addr_t rd_reg;
	status_t status_byte;
	logic [7:0] rd_byte;

	assign wr_reg = axil_req.awaddr[9:2];
	assign rd_reg = axil_req.araddr[9:2];
	assign wr_fire = aw_ready & axil_req.awvalid & axil_req.wvalid;
	assign rd_fire = ar_ready & axil_req.arvalid;

	always_comb begin
		status_byte.zero = 2'b00;
		status_byte.cpub_present = ~cpub_present_n;
		status_byte.wait_err = status.wait_err;
		status_byte.operation_err = status.operation_err;
		status_byte.err_found = status.err_found;
		status_byte.sysen = status.sysen;
		status_byte.sysgood = status.sysgood;
	end

	// Register read decode, high halves carry the top rails with a zero MSB
	always_comb begin
		case (rd_reg)
			reg_version: rd_byte = fpga_version;
			reg_status: rd_byte = status_byte;
			reg_en_lo: rd_byte = status.en[7:0];
			reg_en_hi: rd_byte = {{(8 - hi_bits){1'b0}}, status.en[rail_count-1:8]};
			reg_pg_lo: rd_byte = status.pg[7:0];
			reg_pg_hi: rd_byte = {{(8 - hi_bits){1'b0}}, status.pg[rail_count-1:8]};
			reg_vendor_0: rd_byte = vendor_id[31:24];
			reg_vendor_1: rd_byte = vendor_id[23:16];
			reg_vendor_2: rd_byte = vendor_id[15:8];
			reg_vendor_3: rd_byte = vendor_id[7:0];
			reg_fail_lo: rd_byte = status.fail_detail[7:0];
			reg_fail_hi: rd_byte = {{(8 - hi_bits){1'b0}}, status.fail_detail[rail_count-1:8]};
			reg_sys_override: rd_byte = {7'b0000000, force_enable};
			default: rd_byte = 8'h00;
		endcase
	end

	// Write channel, address and data accepted together
	always_ff @(posedge clk_in) begin
		if (reset) begin
			aw_ready <= 1'b0;
			b_valid <= 1'b0;
			force_enable <= 1'b0;
			clear_err <= 1'b0;
		end else begin
			aw_ready <= axil_req.awvalid & axil_req.wvalid & ~aw_ready & ~b_valid;
			clear_err <= wr_fire && (wr_reg == reg_clear_err);
			if (wr_fire) begin
				b_valid <= 1'b1;
				if (wr_reg == reg_sys_override && axil_req.wstrb[0]) begin
					force_enable <= axil_req.wdata[0];
				end
			end else if (b_valid && axil_req.bready) begin
				b_valid <= 1'b0;
			end
		end
	end

	// Read channel
	always_ff @(posedge clk_in) begin
		if (reset) begin
			ar_ready <= 1'b0;
			r_valid <= 1'b0;
		end else begin
			ar_ready <= axil_req.arvalid & ~ar_ready & ~r_valid;
			if (rd_fire) begin
				r_valid <= 1'b1;
			end else if (r_valid && axil_req.rready) begin
				r_valid <= 1'b0;
			end
		end
	end

	// Read data is held with rvalid
	always_ff @(posedge clk_in) begin
		if (rd_fire) begin
			r_data <= rd_byte;
		end
	end

	assign axil_rsp.awready = aw_ready;
	assign axil_rsp.wready = aw_ready;
	assign axil_rsp.bvalid = b_valid;
	assign axil_rsp.bresp = resp_okay;
	assign axil_rsp.arready = ar_ready;
	assign axil_rsp.rvalid = r_valid;
	assign axil_rsp.rdata = {24'h000000, r_data};
	assign axil_rsp.rresp = resp_okay;

endmodule

/* sequencer/rail_sequencer.sv */
// Rail sequencer
// Steps the rails up in order with a settle delay, watches for missing or lost
// power-good, latches errors with the failing rails and shuts everything down
`timescale 1ns/1ps

module rail_sequencer #(
	parameter int unsigned DELAY_CYCLES = 65536,
	parameter int unsigned TIMEOUT_CYCLES = 8388608,
	parameter int unsigned ATX_TIMEOUT_CYCLES = 67108864
) (
	input logic clk_in,
	input logic reset,
	input logic sysen,
	input logic force_enable,
	input logic bmc_boot_complete_n,
	input pwr_rail_pkg::rail_vec_t pg_sync,
	input logic clear_err,
	output pwr_rail_pkg::rail_vec_t en,
	output pwr_regs_pkg::seq_status_t status,
	output logic sysgood
);
	import pwr_rail_pkg::*;

	localparam int unsigned wait_max =
		(ATX_TIMEOUT_CYCLES > TIMEOUT_CYCLES) ? ATX_TIMEOUT_CYCLES : TIMEOUT_CYCLES;
	localparam int dw = $clog2(DELAY_CYCLES + 1);
	localparam int ww = $clog2(wait_max + 1);
	localparam logic [dw-1:0] delay_last = dw'(DELAY_CYCLES - 1);
	localparam logic [ww-1:0] wait_last = ww'(TIMEOUT_CYCLES - 1);
	localparam logic [ww-1:0] atx_wait_last = ww'(ATX_TIMEOUT_CYCLES - 1);

	logic sysen_s1;
	logic sysen_s2;
	logic sysen_prev;
	rail_vec_t delay_done;
	logic [dw-1:0] d_count;
	logic [ww-1:0] w_count;
	logic wait_err;
	logic operation_err;
	logic err_found;
	logic err_found_d;
	rail_vec_t fail_detail;

	rail_vec_t settle_vec;
	rail_vec_t settle_pick;
	rail_vec_t wait_vec;
	rail_vec_t wait_pick;
	logic [ww-1:0] wait_limit;
	logic counting;
	logic wait_expired;
	logic err_clear;

	// Lowest rail still settling, and lowest rail still waiting for power-good
	assign settle_vec = en & pg_sync & ~delay_done;
	assign settle_pick = settle_vec & (~settle_vec + rail_vec_t'(1));
	assign wait_vec = en & ~pg_sync;
	assign wait_pick = wait_vec & (~wait_vec + rail_vec_t'(1));
	assign wait_limit = wait_pick[rail_idx_atx] ? atx_wait_last : wait_last;

	assign counting = sysen_s2 & ~err_found;
	assign wait_expired = counting & ~(|settle_vec) & (|wait_vec) & (w_count == wait_limit);
	assign err_clear = clear_err | (sysen_prev & ~sysen_s2);

	always_ff @(posedge clk_in) begin
		if (reset) begin
			sysen_s1 <= 1'b0;
			sysen_s2 <= 1'b0;
			sysen_prev <= 1'b0;
		end else begin
			sysen_s1 <= sysen | force_enable;
			sysen_s2 <= sysen_s1;
			sysen_prev <= sysen_s2;
		end
	end

	// Shared settle and timeout counters
	always_ff @(posedge clk_in) begin
		if (reset || !counting) begin
			d_count <= '0;
			w_count <= '0;
			delay_done <= '0;
		end else if (|settle_vec) begin
			w_count <= '0;
			if (d_count == delay_last) begin
				d_count <= '0;
				delay_done <= delay_done | settle_pick;
			end else begin
				d_count <= d_count + 1'b1;
			end
		end else if (|wait_vec) begin
			d_count <= '0;
			if (wait_expired) begin
				w_count <= '0;
			end else begin
				w_count <= w_count + 1'b1;
			end
		end else begin
			d_count <= '0;
			w_count <= '0;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			wait_err <= 1'b0;
			operation_err <= 1'b0;
			err_found <= 1'b0;
			err_found_d <= 1'b0;
			fail_detail <= '0;
		end else begin
			err_found_d <= err_found;
			if (err_clear) begin
				wait_err <= 1'b0;
				operation_err <= 1'b0;
				err_found <= 1'b0;
				fail_detail <= '0;
			end else begin
				if (wait_expired) begin
					wait_err <= 1'b1;
				end
				// A settled rail lost its power-good
				if (|(delay_done & ~pg_sync)) begin
					operation_err <= 1'b1;
				end
				if (wait_err || operation_err) begin
					err_found <= 1'b1;
				end
				if (err_found && !err_found_d) begin
					fail_detail <= en ^ pg_sync;
				end
			end
		end
	end

	// Up after the rail below settles, held while the rail above is still good
	always_ff @(posedge clk_in) begin
		if (reset) begin
			en <= '0;
			sysgood <= 1'b0;
		end else begin
			en <= (({delay_done[rail_count-2:0], 1'b1} & {rail_count{sysen_s2}}) |
				{1'b0, pg_sync[rail_count-1:1]}) & ~{rail_count{err_found}};
			sysgood <= delay_done[rail_count-1] & ~bmc_boot_complete_n;
		end
	end

	assign status.en = en;
	assign status.pg = pg_sync;
	assign status.fail_detail = fail_detail;
	assign status.wait_err = wait_err;
	assign status.operation_err = operation_err;
	assign status.err_found = err_found;
	assign status.sysen = sysen_s2;
	// Host sees sequence completion without the BMC gate
	assign status.sysgood = delay_done[rail_count-1];

endmodule

/* sequencer/rail_io_map.sv */
// Rail pin mapper
// Drives the board enables from the rail vector and brings power-good back
// through a synchronizer, faking good on second-CPU rails when that CPU is absent
`timescale 1ns/1ps

module rail_io_map (
	input logic clk_in,
	input logic reset,
	input logic cpub_present_n,
	input pwr_rail_pkg::rail_pg_pins_t pg_pins,
	input pwr_rail_pkg::rail_vec_t en,
	output pwr_rail_pkg::rail_en_pins_t en_pins,
	output pwr_rail_pkg::rail_vec_t pg_sync,
	output logic cpub_clk_oe
);
	import pwr_rail_pkg::*;

	logic cpub_absent_s1;
	logic cpub_absent;
	rail_vec_t absent_mask;
	rail_vec_t en_masked;
	rail_vec_t pg_raw;
	rail_vec_t pg_s1;
	rail_vec_t pg_s2;

	assign absent_mask = cpub_rail_mask & {rail_count{cpub_absent}};
	assign en_masked = en & ~absent_mask;

	assign pg_raw[rail_idx_atx] = pg_pins.atx_pg;
	assign pg_raw[rail_idx_miscio] = pg_pins.miscio_pg;
	assign pg_raw[rail_idx_vdna] = pg_pins.vdna_pg;
	assign pg_raw[rail_idx_vdnb] = pg_pins.vdnb_pg;
	assign pg_raw[rail_idx_avdd] = pg_pins.avdd_pg;
	assign pg_raw[rail_idx_vioa] = pg_pins.vioa_pg;
	assign pg_raw[rail_idx_viob] = pg_pins.viob_pg;
	assign pg_raw[rail_idx_vdda] = pg_pins.vdda_pg;
	assign pg_raw[rail_idx_vddb] = pg_pins.vddb_pg;
	assign pg_raw[rail_idx_vcsa] = pg_pins.vcsa_pg;
	assign pg_raw[rail_idx_vcsb] = pg_pins.vcsb_pg;
	assign pg_raw[rail_idx_vppab] = pg_pins.vppab_pg;
	assign pg_raw[rail_idx_vppcd] = pg_pins.vppcd_pg;
	assign pg_raw[rail_idx_vddrab] = pg_pins.vddrab_pg;
	assign pg_raw[rail_idx_vddrcd] = pg_pins.vddrcd_pg;

	// Presence strap, treated as absent until sampled
	always_ff @(posedge clk_in) begin
		if (reset) begin
			cpub_absent_s1 <= 1'b1;
			cpub_absent <= 1'b1;
			cpub_clk_oe <= 1'b0;
		end else begin
			cpub_absent_s1 <= cpub_present_n;
			cpub_absent <= cpub_absent_s1;
			cpub_clk_oe <= ~cpub_absent;
		end
	end

	// Two synchronizer stages, then the faked-good merge
	always_ff @(posedge clk_in) begin
		if (reset) begin
			pg_s1 <= '0;
			pg_s2 <= '0;
			pg_sync <= '0;
		end else begin
			pg_s1 <= pg_raw;
			pg_s2 <= pg_s1;
			pg_sync <= pg_s2 | (en & absent_mask);
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset) begin
			en_pins <= '0;
		end else begin
			en_pins.atx_en <= en_masked[rail_idx_atx];
			en_pins.miscio_en <= en_masked[rail_idx_miscio];
			en_pins.vdna_en <= en_masked[rail_idx_vdna];
			en_pins.vdnb_en <= en_masked[rail_idx_vdnb];
			en_pins.avdd_en <= en_masked[rail_idx_avdd];
			en_pins.vioa_en <= en_masked[rail_idx_vioa];
			en_pins.viob_en <= en_masked[rail_idx_viob];
			en_pins.vdda_en <= en_masked[rail_idx_vdda];
			en_pins.vddb_en <= en_masked[rail_idx_vddb];
			en_pins.vcsa_en <= en_masked[rail_idx_vcsa];
			en_pins.vcsb_en <= en_masked[rail_idx_vcsb];
			en_pins.vppab_en <= en_masked[rail_idx_vppab];
			en_pins.vppcd_en <= en_masked[rail_idx_vppcd];
			// Memory supply and its termination come up together
			en_pins.vddrab_en <= en_masked[rail_idx_vddrab];
			en_pins.vttab_en <= en_masked[rail_idx_vddrab];
			en_pins.vddrcd_en <= en_masked[rail_idx_vddrcd];
			en_pins.vttcd_en <= en_masked[rail_idx_vddrcd];
		end
	end

endmodule

/* common/pwr_regs_pkg.sv */
// Host register definitions
// Register numbers, identification values, status layout and AXI4-Lite bundles
package pwr_regs_pkg;

	typedef logic [7:0] reg_addr_t;

	localparam reg_addr_t reg_version = 8'h00;
	localparam reg_addr_t reg_clear_err = 8'h03;
	localparam reg_addr_t reg_status = 8'h07;
	localparam reg_addr_t reg_en_lo = 8'h08;
	localparam reg_addr_t reg_en_hi = 8'h09;
	localparam reg_addr_t reg_pg_lo = 8'h0a;
	localparam reg_addr_t reg_pg_hi = 8'h0b;
	localparam reg_addr_t reg_vendor_0 = 8'h0c;
	localparam reg_addr_t reg_vendor_1 = 8'h0d;
	localparam reg_addr_t reg_vendor_2 = 8'h0e;
	localparam reg_addr_t reg_vendor_3 = 8'h0f;
	localparam reg_addr_t reg_fail_lo = 8'h18;
	localparam reg_addr_t reg_fail_hi = 8'h19;
	localparam reg_addr_t reg_sys_override = 8'h33;

	localparam logic [7:0] fpga_version = 8'h09;

	// ASCII "RCS ", first character in the top byte
	localparam logic [31:0] vendor_id = 32'h52435320;

	localparam logic [1:0] resp_okay = 2'b00;

	typedef struct packed {
		logic [1:0] zero;
		logic cpub_present;
		logic wait_err;
		logic operation_err;
		logic err_found;
		logic sysen;
		logic sysgood;
	} status_t;

	// Sequencer state seen by the host
	typedef struct packed {
		pwr_rail_pkg::rail_vec_t en;
		pwr_rail_pkg::rail_vec_t pg;
		pwr_rail_pkg::rail_vec_t fail_detail;
		logic wait_err;
		logic operation_err;
		logic err_found;
		logic sysen;
		logic sysgood;
	} seq_status_t;

	typedef struct packed {
		logic awvalid;
		logic [9:0] awaddr;
		logic wvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic bready;
		logic arvalid;
		logic [9:0] araddr;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

/* common/pwr_rail_pkg.sv */
// Power rail definitions
// Rail ordering, second-CPU rail mask and the board pin bundles
package pwr_rail_pkg;

	localparam int rail_count = 15;

	typedef logic [rail_count-1:0] rail_vec_t;

	// Sequencing order, lowest rail starts first
	localparam int rail_idx_atx = 0;
	localparam int rail_idx_miscio = 1;
	localparam int rail_idx_vdna = 2;
	localparam int rail_idx_vdnb = 3;
	localparam int rail_idx_avdd = 4;
	localparam int rail_idx_vioa = 5;
	localparam int rail_idx_viob = 6;
	localparam int rail_idx_vdda = 7;
	localparam int rail_idx_vddb = 8;
	localparam int rail_idx_vcsa = 9;
	localparam int rail_idx_vcsb = 10;
	localparam int rail_idx_vppab = 11;
	localparam int rail_idx_vppcd = 12;
	localparam int rail_idx_vddrab = 13;
	localparam int rail_idx_vddrcd = 14;

	// Rails 3, 6, 8, 10, 12 and 14 feed the second CPU
	localparam rail_vec_t cpub_rail_mask = 15'h5548;

	// Board enable outputs, DDR and VTT share one rail each
	typedef struct packed {
		logic atx_en;
		logic miscio_en;
		logic vdna_en;
		logic vdnb_en;
		logic avdd_en;
		logic vioa_en;
		logic viob_en;
		logic vdda_en;
		logic vddb_en;
		logic vcsa_en;
		logic vcsb_en;
		logic vppab_en;
		logic vppcd_en;
		logic vddrab_en;
		logic vttab_en;
		logic vddrcd_en;
		logic vttcd_en;
	} rail_en_pins_t;

	// Board power-good inputs
	typedef struct packed {
		logic atx_pg;
		logic miscio_pg;
		logic vdna_pg;
		logic vdnb_pg;
		logic avdd_pg;
		logic vioa_pg;
		logic viob_pg;
		logic vdda_pg;
		logic vddb_pg;
		logic vcsa_pg;
		logic vcsb_pg;
		logic vppab_pg;
		logic vppcd_pg;
		logic vddrab_pg;
		logic vddrcd_pg;
	} rail_pg_pins_t;

endpackage
